/* src/stepper_pkg.sv */
package stepper_pkg;

  // Sizes
  localparam int NUM_MOTORS    = 2;
  localparam int BUFFER_SIZE   = 2;
  localparam int BUFFER_BITS   = 1;  // Slot index width
  localparam int DURATION_BITS = 32; // Move length in DDA ticks
  localparam int RATE_BITS     = 64;
  localparam int POSITION_BITS = 32;
  localparam int WORD_BITS     = 64;

  // Command codes, carried in bits 63:56 of a header word
  localparam logic [7:0] CMD_COORDINATED_STEP = 8'h01;
  localparam logic [7:0] CMD_MOTOR_ENABLE     = 8'h0a;
  localparam logic [7:0] CMD_MOTOR_BRAKE      = 8'h0b;
  localparam logic [7:0] CMD_CLK_DIVISOR      = 8'h20;
  localparam logic [7:0] CMD_STEPPERFAULT     = 8'h50;
  localparam logic [7:0] CMD_API_VERSION      = 8'hfe;

  localparam logic [7:0] DEFAULT_CLOCK_DIVISOR = 8'd32;

  // Reported by the version command, patch in byte 0
  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd0;
  localparam logic [7:0] VERSION_DEVEL = 8'd1;

  typedef logic [NUM_MOTORS-1:0] motor_vec_t;

  typedef logic signed [POSITION_BITS-1:0] position_t;

  // Second-order DDA parameters of one axis
  typedef struct packed {
    logic [RATE_BITS-1:0] increment;
    logic [RATE_BITS-1:0] increment_increment;
  } axis_rate_t;

  // One buffered coordinated move
  typedef struct packed {
    logic [DURATION_BITS-1:0]         duration;
    motor_vec_t                       dir;
    axis_rate_t [NUM_MOTORS-1:0]      rate; // Index 0 is motor 0
  } move_t;

endpackage

/* src/command_decoder.sv */
`timescale 1ns/100ps

module command_decoder import stepper_pkg::*; (
  input  logic                         CLK,
  input  logic                         resetn,
  input  logic [WORD_BITS-1:0]         word_data_received,
  input  logic                         word_received,
  input  motor_vec_t                   fault_n,
  input  position_t [NUM_MOTORS-1:0]   positions,
  output logic [WORD_BITS-1:0]         word_send_data,
  output logic                         move_write,
  output move_t                        move_data,
  output motor_vec_t                   enable,
  output motor_vec_t                   brake,
  output logic [7:0]                   clock_divisor
);

  logic [1:0] sync_q;      // Two-stage synchronizer
  logic       sync_prev;
  logic       word_strobe; // One cycle per new word
  logic [7:0] header;
  logic [7:0] word_count;
  logic       move_open;
  logic [7:0] code;

  position_t [NUM_MOTORS-1:0] pos_snap; // Positions at move header

  assign move_open = (header == CMD_COORDINATED_STEP);
  assign code      = word_data_received[WORD_BITS-1:WORD_BITS-8];

  // Sign extension of a position into a reply word
  function automatic logic [WORD_BITS-1:0] pos_word(position_t p);
    return WORD_BITS'(p);
  endfunction

  always_ff @(posedge CLK) begin
    if (resetn) begin
      sync_q         <= '0;
      sync_prev      <= 1'b0;
      word_strobe    <= 1'b0;
      header         <= '0;
      word_count     <= '0;
      word_send_data <= '0;
      move_write     <= 1'b0;
      enable         <= '0;
      brake          <= '0;
      clock_divisor  <= DEFAULT_CLOCK_DIVISOR;
    end else begin
      sync_q      <= {sync_q[0], word_received};
      sync_prev   <= sync_q[1];
      word_strobe <= sync_q[1] & ~sync_prev; // Rising edge
      move_write  <= 1'b0;
      if (word_strobe) begin
        word_send_data <= '0;
        if (!move_open) begin
          header     <= code;
          word_count <= 8'd1;
          case (code)
            CMD_MOTOR_ENABLE: enable <= word_data_received[NUM_MOTORS-1:0];
            CMD_MOTOR_BRAKE:  brake <= word_data_received[NUM_MOTORS-1:0];
            CMD_CLK_DIVISOR:  clock_divisor <= word_data_received[7:0];
            CMD_STEPPERFAULT: word_send_data <= WORD_BITS'(fault_n);
            CMD_API_VERSION: begin
              word_send_data[31:0] <= {VERSION_DEVEL, VERSION_MAJOR,
                                       VERSION_MINOR, VERSION_PATCH};
            end
            default: ; // Move header and unknown codes reply zero
          endcase
        end else begin
          word_count <= word_count + 8'd1;
          if (word_count == 8'd1)
            word_send_data <= pos_word(pos_snap[0]); // After duration
          for (int m = 0; m < NUM_MOTORS - 1; m++) begin
            if (word_count == 8'(3 + 2 * m))
              word_send_data <= pos_word(pos_snap[m+1]);
          end
          if (word_count == 8'(2 * NUM_MOTORS + 1)) begin // Last word of move
            move_write <= 1'b1;
            header     <= '0;
            word_count <= '0;
          end
        end
      end
    end
  end

  // Move assembly
  always_ff @(posedge CLK) begin
    if (word_strobe) begin
      if (!move_open && code == CMD_COORDINATED_STEP) begin
        move_data.dir <= word_data_received[NUM_MOTORS-1:0];
        pos_snap      <= positions;
      end else if (move_open) begin
        if (word_count == 8'd1)
          move_data.duration <= word_data_received[DURATION_BITS-1:0];
        for (int m = 0; m < NUM_MOTORS; m++) begin
          if (word_count == 8'(2 + 2 * m))
            move_data.rate[m].increment <= word_data_received[RATE_BITS-1:0];
          if (word_count == 8'(3 + 2 * m))
            move_data.rate[m].increment_increment <= word_data_received[RATE_BITS-1:0];
        end
      end
    end
  end

endmodule

/* src/move_buffer.sv */
`timescale 1ns/100ps

module move_buffer import stepper_pkg::*; (
  input  logic  CLK,
  input  logic  resetn,
  input  logic  move_write,
  input  move_t move_data,
  input  logic  move_done,
  output logic  move_available,
  output move_t head_move,
  output logic  buffer_dtr
);

  move_t                  slots [BUFFER_SIZE];
  logic [BUFFER_SIZE-1:0] full;
  logic [BUFFER_BITS-1:0] wr_ptr;
  logic [BUFFER_BITS-1:0] rd_ptr;

  always_ff @(posedge CLK) begin
    if (move_write)
      slots[wr_ptr] <= move_data;
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      full   <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (move_done) begin
        full[rd_ptr] <= 1'b0;
        rd_ptr       <= rd_ptr + BUFFER_BITS'(1);
      end
      // A write into the slot being retired wins
      if (move_write) begin
        full[wr_ptr] <= 1'b1;
        wr_ptr       <= wr_ptr + BUFFER_BITS'(1);
      end
    end
  end

  assign move_available = full[rd_ptr];
  assign head_move      = slots[rd_ptr];
  assign buffer_dtr     = ~full[wr_ptr]; // Room for the next move

endmodule

/* src/tick_divider.sv */
`timescale 1ns/100ps

module tick_divider import stepper_pkg::*; (
  input  logic       CLK,
  input  logic       resetn,
  input  logic [7:0] clock_divisor,
  output logic       dda_tick
);

  logic [7:0] count;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      count    <= '0;
      dda_tick <= 1'b0;
    end else begin
      dda_tick <= 1'b0;
      if (count == 8'd0) begin
        if (clock_divisor != 8'd0) begin // Zero divisor stops the ticks
          dda_tick <= 1'b1;
          count    <= clock_divisor - 8'd1;
        end
      end else begin
        count <= count - 8'd1;
      end
    end
  end

endmodule

/* src/move_sequencer.sv */
`timescale 1ns/100ps

module move_sequencer import stepper_pkg::*; (
  input  logic                     CLK,
  input  logic                     resetn,
  input  logic                     dda_tick,
  input  logic                     move_available,
  input  logic [DURATION_BITS-1:0] duration,
  output logic                     loading_move,
  output logic                     executing,
  output logic                     move_done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_RUN
  } seq_state_t;

  seq_state_t               state;
  logic [DURATION_BITS-1:0] tick_count;
  logic                     last_tick;

  // Zero duration is treated as a single tick
  assign last_tick = (tick_count == duration - 1'b1) || (duration == '0);

  assign loading_move = (state == ST_LOAD);
  assign executing    = (state == ST_RUN);
  assign move_done    = (state == ST_RUN) && dda_tick && last_tick;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state      <= ST_IDLE;
      tick_count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (move_available)
            state <= ST_LOAD;
        end
        ST_LOAD: begin
          tick_count <= '0;
          state      <= ST_RUN;
        end
        ST_RUN: begin
          if (dda_tick) begin
            if (last_tick)
              state <= ST_IDLE; // Slot is freed by move_done
            else
              tick_count <= tick_count + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* src/step_timer.sv */
`timescale 1ns/100ps

module step_timer import stepper_pkg::*; (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       dda_tick,
  input  logic       loading_move,
  input  logic       executing,
  input  axis_rate_t axis_rate,
  input  logic       dir,
  output logic       step,
  output position_t  position
);

  logic [RATE_BITS-1:0] accum;
  logic [RATE_BITS-1:0] rate;
  logic [RATE_BITS-1:0] rate_inc;
  logic [RATE_BITS:0]   sum;     // Carry in the top bit
  logic                 advance;

  assign sum     = {1'b0, accum} + {1'b0, rate};
  assign advance = executing && dda_tick;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      accum    <= '0;
      step     <= 1'b0;
      position <= '0;
    end else begin
      step <= 1'b0;
      if (loading_move) begin
        accum <= '0;
      end else if (advance) begin
        accum <= sum[RATE_BITS-1:0];
        step  <= sum[RATE_BITS];
        if (sum[RATE_BITS])
          position <= dir ? position + 1 : position - 1;
      end
    end
  end

  // Rate ramps by increment_increment once per tick
  always_ff @(posedge CLK) begin
    if (loading_move) begin
      rate     <= axis_rate.increment;
      rate_inc <= axis_rate.increment_increment;
    end else if (advance) begin
      rate <= rate + rate_inc;
    end
  end

endmodule

/* src/step_controller_top.sv */
`timescale 1ns/100ps

module step_controller_top import stepper_pkg::*; (
  input  logic                 CLK,
  input  logic                 resetn,
  input  logic [WORD_BITS-1:0] word_data_received,
  input  logic                 word_received,
  input  motor_vec_t           fault_n,
  input  logic                 halt,  // Not used by this controller
  output logic [WORD_BITS-1:0] word_send_data,
  output logic                 buffer_dtr,
  output logic                 move_done,
  output motor_vec_t           step,
  output motor_vec_t           dir,
  output motor_vec_t           enable,
  output motor_vec_t           brake
);

  logic                       move_write;
  move_t                      move_data;
  move_t                      head_move;
  logic                       move_available;
  logic [7:0]                 clock_divisor;
  logic                       dda_tick;
  logic                       loading_move;
  logic                       executing;
  position_t [NUM_MOTORS-1:0] positions;

  assign dir = head_move.dir; // Direction of the move in progress

  command_decoder command_decoder_inst (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .fault_n            (fault_n),
    .positions          (positions),
    .word_send_data     (word_send_data),
    .move_write         (move_write),
    .move_data          (move_data),
    .enable             (enable),
    .brake              (brake),
    .clock_divisor      (clock_divisor)
  );

  move_buffer move_buffer_inst (
    .CLK            (CLK),
    .resetn         (resetn),
    .move_write     (move_write),
    .move_data      (move_data),
    .move_done      (move_done),
    .move_available (move_available),
    .head_move      (head_move),
    .buffer_dtr     (buffer_dtr)
  );

  tick_divider tick_divider_inst (
    .CLK           (CLK),
    .resetn        (resetn),
    .clock_divisor (clock_divisor),
    .dda_tick      (dda_tick)
  );

  move_sequencer move_sequencer_inst (
    .CLK            (CLK),
    .resetn         (resetn),
    .dda_tick       (dda_tick),
    .move_available (move_available),
    .duration       (head_move.duration),
    .loading_move   (loading_move),
    .executing      (executing),
    .move_done      (move_done)
  );

  for (genvar i = 0; i < NUM_MOTORS; i++) begin : g_axis
    step_timer step_timer_inst (
      .CLK          (CLK),
      .resetn       (resetn),
      .dda_tick     (dda_tick),
      .loading_move (loading_move),
      .executing    (executing),
      .axis_rate    (head_move.rate[i]),
      .dir          (head_move.dir[i]),
      .step         (step[i]),
      .position     (positions[i])
    );
  end

endmodule

/* test/tb_step_controller.sv */
`timescale 1ns/100ps

module tb_step_controller import stepper_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 20000; // All tests take under 2000 cycles

  logic                 CLK;
  logic                 resetn;
  logic [WORD_BITS-1:0] word_data_received;
  logic                 word_received;
  motor_vec_t           fault_n;
  logic                 halt;
  logic [WORD_BITS-1:0] word_send_data;
  logic                 buffer_dtr;
  logic                 move_done;
  motor_vec_t           step;
  motor_vec_t           dir;
  motor_vec_t           enable;
  motor_vec_t           brake;

  int         errors = 0;
  int         checks = 0;
  int         cycles = 0;
  int         done_count = 0;
  int         step_count [NUM_MOTORS] = '{0, 0};
  motor_vec_t dir_at_done;

  step_controller_top step_controller_top_inst (.*);

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  // Counts step pulses and move ends outside reset
  always @(negedge CLK) begin
    if (!resetn) begin
      for (int i = 0; i < NUM_MOTORS; i++)
        if (step[i]) step_count[i]++;
      if (move_done) begin
        done_count++;
        dir_at_done = dir; // Head move still in place here
      end
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [WORD_BITS-1:0] got,
                             input logic [WORD_BITS-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Strobe held two cycles, reply read five cycles after it drops
  task automatic send_word(input logic [WORD_BITS-1:0] w, output logic [WORD_BITS-1:0] reply);
    @(negedge CLK);
    word_data_received = w;
    word_received      = 1'b1;
    repeat (2) @(negedge CLK);
    word_received = 1'b0;
    repeat (5) @(negedge CLK);
    reply = word_send_data;
  endtask

  // Six-word coordinated move, returns both position replies
  task automatic send_move(input motor_vec_t d, input logic [31:0] dur,
                           input logic [63:0] inc0, input logic [63:0] ii0,
                           input logic [63:0] inc1, input logic [63:0] ii1,
                           output logic [63:0] pos0, output logic [63:0] pos1);
    logic [63:0] r;
    send_word({CMD_COORDINATED_STEP, 56'(d)}, r);
    check_value("reply after header", r, '0);
    send_word(64'(dur), pos0);
    send_word(inc0, r);
    check_value("reply after increment 0", r, '0);
    send_word(ii0, pos1);
    send_word(inc1, r);
    check_value("reply after increment 1", r, '0);
    send_word(ii1, r);
    check_value("reply after last word", r, '0);
  endtask

  task automatic wait_done(input int target);
    while (done_count < target)
      @(negedge CLK);
  endtask

  // Constant rate: floor(d * r / 2^64)
  function automatic int floor_steps(input logic [31:0] d, input logic [63:0] r);
    logic [95:0] prod;
    prod = 96'(d) * 96'(r);
    return int'(prod[95:64]);
  endfunction

  // Ramping rate: floor of the summed per-tick rates over 2^64
  function automatic int dda_steps(input logic [63:0] inc, input logic [63:0] inc_inc,
                                   input int ticks);
    logic [127:0] total;
    total = '0;
    for (int t = 0; t < ticks; t++)
      total = total + 128'(inc) + 128'(inc_inc) * 128'(t);
    return int'(total[127:64]);
  endfunction

  task automatic reset_and_version();
    logic [63:0] r;
    check_value("buffer_dtr", 64'(buffer_dtr), 64'd1);
    check_value("move_done", 64'(move_done), 64'd0);
    check_value("enable", 64'(enable), 64'd0);
    check_value("brake", 64'(brake), 64'd0);
    send_word({CMD_API_VERSION, 56'd0}, r);
    check_value("version reply", r,
                {32'd0, VERSION_DEVEL, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH});
  endtask

  task automatic enable_brake_fault();
    logic [63:0] r;
    motor_vec_t  mask;
    for (int n = 0; n < 3; n++) begin
      mask = motor_vec_t'($urandom);
      send_word({CMD_MOTOR_ENABLE, 56'(mask)}, r);
      check_value("enable", 64'(enable), 64'(mask));
      mask = motor_vec_t'($urandom);
      send_word({CMD_MOTOR_BRAKE, 56'(mask)}, r);
      check_value("brake", 64'(brake), 64'(mask));
      fault_n = motor_vec_t'($urandom);
      send_word({CMD_STEPPERFAULT, 56'd0}, r);
      check_value("fault readback", r, 64'(fault_n));
    end
  endtask

  task automatic single_move();
    logic [63:0] p0;
    logic [63:0] p1;
    logic [63:0] r;
    int          base_done;
    int          base0;
    int          base1;
    send_word({CMD_CLK_DIVISOR, 56'd4}, r);
    base_done = done_count;
    base0     = step_count[0];
    base1     = step_count[1];
    send_move(2'b01, 32'd16, 64'd1 << 62, 64'd0, 64'd1 << 61, 64'd0, p0, p1);
    wait_done(base_done + 1);
    repeat (8) @(negedge CLK);
    check_value("motor 0 steps", 64'(step_count[0] - base0), 64'(floor_steps(16, 64'd1 << 62)));
    check_value("motor 1 steps", 64'(step_count[1] - base1), 64'(floor_steps(16, 64'd1 << 61)));
    check_value("move_done pulses", 64'(done_count - base_done), 64'd1);
    check_value("dir", 64'(dir_at_done), 64'd1);
  endtask

  task automatic position_readback();
    logic [63:0] p0;
    logic [63:0] p1;
    int          base_done;
    base_done = done_count;
    send_move(2'b00, 32'd4, 64'd0, 64'd0, 64'd0, 64'd0, p0, p1);
    check_value("motor 0 position reply", p0, 64'd4);
    check_value("motor 1 position reply", p1, 64'(-2)); // Sign extended
    wait_done(base_done + 1);
  endtask

  task automatic back_to_back_moves();
    logic [63:0] p0;
    logic [63:0] p1;
    int          base_done;
    base_done = done_count;
    send_move(2'b10, 32'd40, 64'd1 << 60, 64'd0, 64'd1 << 60, 64'd0, p0, p1);
    send_move(2'b01, 32'd8, 64'd1 << 62, 64'd0, 64'd0, 64'd0, p0, p1);
    check_value("buffer_dtr with both slots full", 64'(buffer_dtr), 64'd0);
    wait_done(base_done + 2);
    @(negedge CLK);
    check_value("buffer_dtr after both moves", 64'(buffer_dtr), 64'd1);
  endtask

  task automatic ramped_move();
    logic [63:0] p0;
    logic [63:0] p1;
    int          base_done;
    int          base0;
    int          base1;
    base_done = done_count;
    base0     = step_count[0];
    base1     = step_count[1];
    send_move(2'b11, 32'd8, 64'd0, 64'd1 << 60, 64'd0, 64'd1 << 61, p0, p1);
    wait_done(base_done + 1);
    repeat (2) @(negedge CLK);
    check_value("motor 0 ramp steps", 64'(step_count[0] - base0),
                64'(dda_steps(64'd0, 64'd1 << 60, 8)));
    check_value("motor 1 ramp steps", 64'(step_count[1] - base1),
                64'(dda_steps(64'd0, 64'd1 << 61, 8)));
  endtask

  initial begin
    void'($urandom(32'h5a46_aee0));
    resetn             = 1'b1;
    word_data_received = '0;
    word_received      = 1'b0;
    fault_n            = '1;
    halt               = 1'b0;
    repeat (2) @(negedge CLK);
    resetn = 1'b0;
    reset_and_version();
    enable_brake_fault();
    single_move();
    position_readback();
    back_to_back_moves();
    ramped_move();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* tb.f */
src/stepper_pkg.sv
src/command_decoder.sv
src/move_buffer.sv
src/tick_divider.sv
src/move_sequencer.sv
src/step_timer.sv
src/step_controller_top.sv
test/tb_step_controller.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary -j 0 -Wno-fatal
TOP       ?= tb_step_controller
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "No result in log"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
